// ==== bench/rx_backend_asserts.sv ====
`timescale 1ns/1ps

module rx_backend_asserts (
    input logic clk,
    input logic rst_n_i,
    input logic sample_vld_i,
    input logic store_o,
    input logic sym_vld_o,
    input logic word_vld_o
);

    logic accept;        // same gate as in the top level
    int   fail_cnt = 0;  // assertion failures so far

    assign accept = sample_vld_i && store_o;

    // accepted sample -> symbol strobe next cycle
    property sym_follows_accept;
        @(posedge clk) disable iff (!rst_n_i)
        accept |=> sym_vld_o;
    endproperty

    // no symbol strobe without an accept one cycle before
    property sym_needs_accept;
        @(posedge clk) disable iff (!rst_n_i)
        sym_vld_o |-> $past(accept);
    endproperty

    property word_single_pulse;
        @(posedge clk) disable iff (!rst_n_i)
        word_vld_o |=> !word_vld_o;
    endproperty

    // outputs quiet in the cycle after a reset cycle
    property quiet_after_reset;
        @(posedge clk)
        !rst_n_i |=> (!store_o && !sym_vld_o && !word_vld_o);
    endproperty

    a_sym_follows_accept : assert property (sym_follows_accept)
        else begin
            $error("sym_vld_o missing one cycle after an accepted sample");
            fail_cnt++;
        end
    a_sym_needs_accept : assert property (sym_needs_accept)
        else begin
            $error("sym_vld_o without an accepted sample one cycle before");
            fail_cnt++;
        end
    a_word_single_pulse : assert property (word_single_pulse)
        else begin
            $error("word_vld_o high for two cycles in a row");
            fail_cnt++;
        end
    a_quiet_after_reset : assert property (quiet_after_reset)
        else begin
            $error("store_o, sym_vld_o or word_vld_o high right after reset");
            fail_cnt++;
        end

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 4,  // full clock period
    parameter int RST_CYCLES = 8   // cycles with reset low
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // sync release on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== bench/tb_rx_backend.sv ====
`timescale 1ns/1ps
`include "rx_params.svh"

module tb_rx_backend;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RST_CYCLES    = 8;
    localparam int MAX_GAP       = 3;  // idle cycles before a sample, at most
    localparam int MAG_MAX       = (1 << (`RX_SAMPLE_W - 1)) - 1;

    // samples driven per test, sop cycles with a sample included
    localparam int N_PRE     = 8;
    localparam int N_QUAD    = 16;
    localparam int N_ERR     = 1 + 32;
    localparam int N_DLY7    = 7 + 48;
    localparam int N_RESYNC  = 1 + 3 + 10 + 3 + 16 + 4;
    localparam int N_SAMPLES = N_PRE + N_QUAD + N_ERR + N_DLY7 + N_RESYNC;
    localparam int EXP_WORDS = 1 + 2 + 3 + 1;

    localparam int WATCHDOG_CYCLES = N_SAMPLES * (MAX_GAP + 1) + 100 + RST_CYCLES;

    logic                 clk;
    logic                 rst_n;
    rx_pkg::iq_sample_t   sample;
    logic                 sample_vld;
    logic                 sop;
    logic [`RX_DLY_W-1:0] store_dly;
    logic                 store;
    rx_pkg::qpsk_sym_t    sym;
    logic                 sym_vld;
    rx_pkg::rx_word_t     word;
    logic                 word_vld;

    // reference model state
    logic                  m_armed;
    int                    m_cnt;       // skipped samples
    logic                  m_pend_vld;  // symbol leaving the slicer next cycle
    rx_pkg::qpsk_sym_t     m_pend_sym;
    logic [`RX_WORD_W-1:0] m_shift;
    int                    m_nsym;      // symbols in current word
    logic                  m_err;
    logic                  exp_store;   // store_o for the cycle just driven
    int                    cur_dly;

    rx_pkg::qpsk_sym_t exp_syms[$];
    rx_pkg::rx_word_t  exp_words[$];

    int n_syms;
    int n_words;
    int n_mismatch;
    int n_other;

    tb_clk_gen #(
        .PERIOD_NS  (CLK_PERIOD_NS),
        .RST_CYCLES (RST_CYCLES)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rx_backend_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .sample_i     (sample),
        .sample_vld_i (sample_vld),
        .sop_i        (sop),
        .store_dly_i  (store_dly),
        .store_o      (store),
        .sym_o        (sym),
        .sym_vld_o    (sym_vld),
        .word_o       (word),
        .word_vld_o   (word_vld)
    );

    bind rx_backend_top rx_backend_asserts u_asserts (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .sample_vld_i (sample_vld_i),
        .store_o      (store_o),
        .sym_vld_o    (sym_vld_o),
        .word_vld_o   (word_vld_o)
    );

    // hard decision straight from the quadrant table
    function automatic rx_pkg::qpsk_sym_t slice_ref(input rx_pkg::iq_sample_t smp);
        rx_pkg::qpsk_sym_t s;
        s.err = 1'b0;
        if (smp.i == 0 || smp.q == 0) begin
            s.code = 2'b00;
            s.err  = 1'b1;  // undecided
        end else if (smp.i > 0 && smp.q > 0) begin
            s.code = 2'b00;
        end else if (smp.i > 0 && smp.q < 0) begin
            s.code = 2'b10;
        end else if (smp.i < 0 && smp.q > 0) begin
            s.code = 2'b01;
        end else begin
            s.code = 2'b11;
        end
        return s;
    endfunction

    // one clock of the whole back end, fills the expected queues
    function automatic void model_step(input logic sop_in, input logic vld_in,
                                       input rx_pkg::iq_sample_t smp);
        logic             st;
        rx_pkg::rx_word_t w;
        st        = m_armed && (m_cnt >= cur_dly) && !sop_in;
        exp_store = st;
        // packer works on last cycle's decision
        if (sop_in) begin
            m_nsym = 0;  // partial word dropped
            m_err  = 1'b0;
        end else if (m_pend_vld) begin
            m_shift = (m_shift << `RX_SYM_W) | m_pend_sym.code;
            m_err   = m_err | m_pend_sym.err;
            m_nsym++;
            if (m_nsym == `RX_SYMS_PER_WORD) begin
                w.data = m_shift;
                w.err  = m_err;
                exp_words.push_back(w);
                m_nsym = 0;
                m_err  = 1'b0;
            end
        end
        // store window
        if (sop_in) begin
            m_armed = 1'b1;
            m_cnt   = 0;
        end else if (m_armed && vld_in && m_cnt < cur_dly) begin
            m_cnt++;
        end
        m_pend_vld = vld_in && st;
        if (m_pend_vld) begin
            m_pend_sym = slice_ref(smp);
            exp_syms.push_back(m_pend_sym);
        end
    endfunction

    function automatic rx_pkg::iq_sample_t make_sample(input logic i_neg, input logic q_neg);
        rx_pkg::iq_sample_t s;
        logic signed [`RX_SAMPLE_W-1:0] mag_i;
        logic signed [`RX_SAMPLE_W-1:0] mag_q;
        mag_i = `RX_SAMPLE_W'($urandom_range(MAG_MAX, 1));
        mag_q = `RX_SAMPLE_W'($urandom_range(MAG_MAX, 1));
        s.i   = i_neg ? -mag_i : mag_i;
        s.q   = q_neg ? -mag_q : mag_q;
        return s;
    endfunction

    function automatic rx_pkg::iq_sample_t rand_sample();
        return make_sample(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
    endfunction

    // one component forced to zero
    function automatic rx_pkg::iq_sample_t zero_sample(input logic zero_i);
        rx_pkg::iq_sample_t s;
        s = rand_sample();
        if (zero_i) begin
            s.i = '0;
        end else begin
            s.q = '0;
        end
        return s;
    endfunction

    task automatic drive_cycle(input logic sop_in, input logic vld_in,
                               input rx_pkg::iq_sample_t smp);
        @(posedge clk);
        sop        <= sop_in;
        sample_vld <= vld_in;
        sample     <= smp;
        store_dly  <= cur_dly[`RX_DLY_W-1:0];
        model_step(sop_in, vld_in, smp);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) drive_cycle(1'b0, 1'b0, rand_sample());  // junk payload
    endtask

    task automatic send_sample(input rx_pkg::iq_sample_t smp);
        drive_idle($urandom_range(MAX_GAP, 0));
        drive_cycle(1'b0, 1'b1, smp);
    endtask

    task automatic start_packet(input int dly, input logic with_sample);
        cur_dly = dly;
        drive_cycle(1'b1, with_sample, rand_sample());
    endtask

    // compare at the falling edge, outputs settled
    always @(negedge clk) begin : compare
        rx_pkg::qpsk_sym_t exp_sym;
        rx_pkg::rx_word_t  exp_word;
        if (rst_n === 1'b1) begin
            if (store !== exp_store) begin
                $display("mismatch at %0t: store_o is %b, expected %b",
                         $time, store, exp_store);
                n_mismatch++;
            end
            if (sym_vld === 1'b1) begin
                if (exp_syms.size() == 0) begin
                    $display("error at %0t: sym_vld_o pulsed with no symbol expected", $time);
                    n_other++;
                end else begin
                    exp_sym = exp_syms.pop_front();
                    n_syms++;
                    if (sym !== exp_sym) begin
                        $display("mismatch at %0t: symbol code %b err %b, expected %b err %b",
                                 $time, sym.code, sym.err, exp_sym.code, exp_sym.err);
                        n_mismatch++;
                    end
                end
            end else if (sym_vld !== 1'b0) begin
                $display("error at %0t: sym_vld_o is unknown", $time);
                n_other++;
            end
            if (word_vld === 1'b1) begin
                if (exp_words.size() == 0) begin
                    $display("error at %0t: word_vld_o pulsed with no word expected", $time);
                    n_other++;
                end else begin
                    exp_word = exp_words.pop_front();
                    n_words++;
                    if (word !== exp_word) begin
                        $display("mismatch at %0t: word %h err %b, expected %h err %b",
                                 $time, word.data, word.err, exp_word.data, exp_word.err);
                        n_mismatch++;
                    end
                end
            end else if (word_vld !== 1'b0) begin
                $display("error at %0t: word_vld_o is unknown", $time);
                n_other++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'h6e09));
        sop        = 1'b0;
        sample_vld = 1'b0;
        sample     = '0;
        store_dly  = '0;
        m_armed    = 1'b0;
        m_cnt      = 0;
        m_pend_vld = 1'b0;
        m_pend_sym = '0;
        m_shift    = '0;
        m_nsym     = 0;
        m_err      = 1'b0;
        exp_store  = 1'b0;
        cur_dly    = 0;
        n_syms     = 0;
        n_words    = 0;
        n_mismatch = 0;
        n_other    = 0;

        wait (rst_n === 1'b1);

        // nothing stored before the first sop
        drive_idle(10);
        for (int k = 0; k < N_PRE; k++) begin
            send_sample(rand_sample());
        end

        // all four quadrants, no skip
        start_packet(0, 1'b0);
        for (int k = 0; k < N_QUAD; k++) begin
            send_sample(make_sample(k[1], k[0]));
        end
        drive_idle(4);

        // zero components in word one, word two clean
        start_packet(1, 1'b0);
        send_sample(rand_sample());  // skipped
        for (int k = 0; k < 32; k++) begin
            if (k == 5) begin
                send_sample(zero_sample(1'b1));
            end else if (k == 9) begin
                send_sample(zero_sample(1'b0));
            end else begin
                send_sample(rand_sample());
            end
        end
        drive_idle(4);

        // seven skipped, three words
        start_packet(7, 1'b0);
        for (int k = 0; k < N_DLY7; k++) begin
            send_sample(rand_sample());
        end
        drive_idle(4);

        // sop with a sample, then a restart in the middle of a word
        start_packet(3, 1'b1);
        for (int k = 0; k < 13; k++) begin
            if (k == 6) begin
                send_sample(zero_sample(1'b1));  // error in the dropped word
            end else begin
                send_sample(rand_sample());
            end
        end
        start_packet(3, 1'b0);  // right after the last accepted sample
        for (int k = 0; k < 3 + 16 + 4; k++) begin
            send_sample(rand_sample());
        end

        // pipeline is two deep
        drive_idle(5);
        @(negedge clk);
        @(posedge clk);

        if (exp_syms.size() != 0) begin
            $display("%0d expected symbols never appeared on sym_o", exp_syms.size());
            n_other++;
        end
        if (exp_words.size() != 0) begin
            $display("%0d expected words never appeared on word_o", exp_words.size());
            n_other++;
        end
        if (n_words != EXP_WORDS) begin
            $display("saw %0d words in total where %0d were expected", n_words, EXP_WORDS);
            n_other++;
        end
        if (dut0.u_asserts.fail_cnt != 0) begin
            $display("%0d bound assertions failed during the run",
                     dut0.u_asserts.fail_cnt);
            n_other += dut0.u_asserts.fail_cnt;
        end

        $display("symbols checked %0d, words checked %0d, mismatches %0d, other errors %0d",
                 n_syms, n_words, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/rx_pkg.sv
rtl/rx_store_ctrl.sv
rtl/rx_qpsk_slicer.sv
rtl/rx_word_packer.sv
rtl/rx_backend_top.sv
bench/tb_clk_gen.sv
bench/rx_backend_asserts.sv
bench/tb_rx_backend.sv

// ==== rtl/rx_backend_top.sv ====
`timescale 1ns/1ps
`include "rx_params.svh"

module rx_backend_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rx_pkg::iq_sample_t   sample_i,      // corrected i/q
    input  logic                 sample_vld_i,
    input  logic                 sop_i,         // packet detect strobe
    input  logic [`RX_DLY_W-1:0] store_dly_i,   // static setting
    output logic                 store_o,       // debug, window open
    output rx_pkg::qpsk_sym_t    sym_o,         // debug, current symbol
    output logic                 sym_vld_o,
    output rx_pkg::rx_word_t     word_o,        // packed data out
    output logic                 word_vld_o
);

    logic accept;  // sample goes into the slicer

    assign accept = sample_vld_i & store_o;

    rx_store_ctrl u_store_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .sop_i        (sop_i),
        .sample_vld_i (sample_vld_i),
        .store_dly_i  (store_dly_i),
        .store_o      (store_o)
    );

    // 1 cycle sample to symbol
    rx_qpsk_slicer u_slicer (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .sample_i  (sample_i),
        .accept_i  (accept),
        .sym_o     (sym_o),
        .sym_vld_o (sym_vld_o)
    );

    // word lands 2 cycles after its last sample
    rx_word_packer u_packer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .sop_i      (sop_i),
        .sym_i      (sym_o),
        .sym_vld_i  (sym_vld_o),
        .word_o     (word_o),
        .word_vld_o (word_vld_o)
    );

endmodule

// ==== rtl/rx_params.svh ====
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// one I or Q component from the front end
`define RX_SAMPLE_W 16

// qpsk carries two bits per symbol
`define RX_SYM_W 2

// symbols collected per output word
`define RX_SYMS_PER_WORD 16

// packed word width, RX_SYM_W * RX_SYMS_PER_WORD
`define RX_WORD_W 32

// store delay setting and its counter
`define RX_DLY_W 16

`endif

// ==== rtl/rx_pkg.sv ====
`include "rx_params.svh"

package rx_pkg;

    // one received sample, i in the low half
    typedef struct packed {
        logic signed [`RX_SAMPLE_W-1:0] q;  // quadrature
        logic signed [`RX_SAMPLE_W-1:0] i;  // in-phase
    } iq_sample_t;

    // one hard decision
    typedef struct packed {
        logic [`RX_SYM_W-1:0] code;  // {q neg, i neg}
        logic                 err;   // a component was zero
    } qpsk_sym_t;

    // one packed word
    typedef struct packed {
        logic [`RX_WORD_W-1:0] data;  // first symbol in msbs
        logic                  err;   // any symbol undecided
    } rx_word_t;

endpackage

// ==== rtl/rx_qpsk_slicer.sv ====
`timescale 1ns/1ps

module rx_qpsk_slicer (
    input  logic               clk,
    input  logic               rst_n_i,
    input  rx_pkg::iq_sample_t sample_i,   // corrected sample
    input  logic               accept_i,   // valid and store window
    output rx_pkg::qpsk_sym_t  sym_o,      // registered decision
    output logic               sym_vld_o   // one cycle after accept
);

    rx_pkg::qpsk_sym_t dec;  // combinational decision
    logic              i_zero;
    logic              q_zero;

    assign i_zero = (sample_i.i == '0);
    assign q_zero = (sample_i.q == '0);

    // quadrant map
    //   i+ q+ -> 00, i+ q- -> 10, i- q+ -> 01, i- q- -> 11
    // so code is just the two sign bits
    always_comb begin
        if (i_zero || q_zero) begin
            dec.code = 2'b00;  // cannot decide
            dec.err  = 1'b1;
        end else begin
            dec.code = {sample_i.q[$bits(sample_i.q)-1],   // q negative
                        sample_i.i[$bits(sample_i.i)-1]};  // i negative
            dec.err  = 1'b0;
        end
    end

    // payload register, loads only on accept
    always_ff @(posedge clk) begin
        if (accept_i) begin
            sym_o <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sym_vld_o <= 1'b0;
        end else begin
            sym_vld_o <= accept_i;  // one item per cycle max
        end
    end

endmodule

// ==== rtl/rx_store_ctrl.sv ====
`timescale 1ns/1ps
`include "rx_params.svh"

module rx_store_ctrl (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 sop_i,         // start of packet strobe
    input  logic                 sample_vld_i,  // one per received sample
    input  logic [`RX_DLY_W-1:0] store_dly_i,   // samples to skip after sop
    output logic                 store_o        // store window open
);

    logic                 armed_q;    // sop seen since reset
    logic [`RX_DLY_W-1:0] dly_cnt_q;  // samples skipped so far
    logic                 dly_done;   // skip count reached
    logic                 cnt_en;

    assign dly_done = (dly_cnt_q >= store_dly_i);

    // only count while armed, stops at the setting
    assign cnt_en = armed_q && sample_vld_i && !dly_done;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            armed_q   <= 1'b0;
            dly_cnt_q <= '0;
        end else if (sop_i) begin  // sop wins over any sample
            armed_q   <= 1'b1;
            dly_cnt_q <= '0;       // recount for the new packet
        end else if (cnt_en) begin
            dly_cnt_q <= dly_cnt_q + 1'b1;
        end
    end

    // window is a decode of state, masked in the sop cycle itself
    // so a sample arriving with sop is never stored
    assign store_o = armed_q && dly_done && !sop_i;

endmodule

// ==== rtl/rx_word_packer.sv ====
`timescale 1ns/1ps
`include "rx_params.svh"

module rx_word_packer (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              sop_i,       // restart packing
    input  rx_pkg::qpsk_sym_t sym_i,       // from slicer
    input  logic              sym_vld_i,
    output rx_pkg::rx_word_t  word_o,      // packed word plus error
    output logic              word_vld_o   // one cycle pulse
);

    localparam int unsigned CNT_W = $clog2(`RX_SYMS_PER_WORD);
    localparam logic [CNT_W-1:0] LAST_SYM = CNT_W'(`RX_SYMS_PER_WORD - 1);

    logic [`RX_WORD_W-1:0] shift_q;  // symbols so far
    logic [`RX_WORD_W-1:0] shift_d;  // with the new symbol
    logic [CNT_W-1:0]      sym_cnt_q;  // position in word
    logic                  err_acc_q;  // sticky over the word
    logic                  take;       // symbol accepted
    logic                  last;       // sixteenth symbol

    // sop drops a symbol landing in the same cycle
    assign take = sym_vld_i && !sop_i;
    assign last = (sym_cnt_q == LAST_SYM);

    // new symbol enters at the lsb end, first one ends up at the top
    assign shift_d = {shift_q[`RX_WORD_W-`RX_SYM_W-1:0], sym_i.code};

    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= shift_d;
        end
    end

    // output word register, no reset on payload
    always_ff @(posedge clk) begin
        if (take && last) begin
            word_o.data <= shift_d;
            word_o.err  <= err_acc_q | sym_i.err;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sym_cnt_q  <= '0;
            err_acc_q  <= 1'b0;
            word_vld_o <= 1'b0;
        end else begin
            word_vld_o <= take && last;  // next cycle after 16th symbol
            if (sop_i) begin             // throw away partial word
                sym_cnt_q <= '0;
                err_acc_q <= 1'b0;
            end else if (take) begin
                sym_cnt_q <= sym_cnt_q + 1'b1;  // wraps to 0 after last
                if (last) begin
                    err_acc_q <= 1'b0;          // fresh for next word
                end else begin
                    err_acc_q <= err_acc_q | sym_i.err;
                end
            end
        end
    end

endmodule
